/* bench/cl_axis_fifo_tb.sv */
`timescale 1ns/1ps

module cl_axis_fifo_tb;

   localparam int DEPTH     = 32;
   localparam int N_BURSTS  = 8;
   localparam int BP_BURSTS = DEPTH / 8 + 1;
   localparam int BP_BEATS  = BP_BURSTS * 8;

   // Rough cycle cost of each test
   // Run limit is four times the sum
   localparam int LEN_RESET  = 20;
   localparam int LEN_BURSTS = N_BURSTS * (8 * 4 + 12);
   localparam int LEN_POP    = (DEPTH + 2) * 5;
   localparam int LEN_ID     = 3 * 5;
   localparam int LEN_BP     = BP_BEATS * 8 + 60;
   localparam int LEN_FLUSH  = 80;
   localparam int CYCLE_LIMIT = 4 * (LEN_RESET + LEN_BURSTS + LEN_POP + LEN_ID
                                     + LEN_BP + LEN_FLUSH);

   logic        clk = 1'b0;
   logic        pipe_rst_n;
   logic        pcis_awvalid, pcis_awready;
   logic [5:0]  pcis_awid;
   logic [7:0]  pcis_awlen;
   logic        pcis_wvalid, pcis_wready;
   logic [31:0] pcis_wdata;
   logic        pcis_wlast;
   logic        pcis_bvalid;
   logic [5:0]  pcis_bid;
   logic        pcis_bready;
   logic        ocl_awvalid, ocl_awready;
   logic [9:0]  ocl_awaddr;
   logic        ocl_wvalid, ocl_wready;
   logic [31:0] ocl_wdata;
   logic        ocl_bvalid, ocl_bready;
   logic        ocl_arvalid, ocl_arready;
   logic [9:0]  ocl_araddr;
   logic        ocl_rvalid;
   logic [31:0] ocl_rdata;
   logic        ocl_rready;
   logic        flr_assert, flr_done;

   logic [31:0] lcg_state;
   logic [31:0] model_q [$];
   int          errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          cycles = 0;

   cl_axis_fifo #(.FIFO_DEPTH(DEPTH)) dut0 (.*);

   always #2 clk = ~clk;

   always @(posedge clk)
   begin
      cycles++;
      if (cycles > CYCLE_LIMIT)
      begin
         $display("Timeout after %0d cycles, a handshake never completed", cycles);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   //////////////////////////////
   // Helpers
   //////////////////////////////

   function automatic logic [31:0] rand_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Upper bits of the LCG are the better ones
   function automatic int rand_below(input int n);
      logic [31:0] r;
      r = rand_next();
      return int'(r[30:16]) % n;
   endfunction

   task automatic check_val(input string name, input logic [31:0] exp_v,
                            input logic [31:0] got_v);
      assert (got_v === exp_v)
      else
      begin
         errors++;
         $display("** Error at %0.1f ns: %s expected 0x%08h, got 0x%08h",
                  $realtime, name, exp_v, got_v);
      end
   endtask

   task automatic finish_test(input string name, input int errs_at_start);
      tests_run++;
      if (errors == errs_at_start)
         $display("[%0.1f ns] %s: ok", $realtime, name);
      else
      begin
         tests_failed++;
         $display("[%0.1f ns] %s: failed with %0d errors", $realtime, name,
                  errors - errs_at_start);
      end
   endtask

   // Inputs change half a ns after the edge
   task automatic step();
      @(posedge clk);
      #0.5;
   endtask

   task automatic ocl_read(input logic [9:0] addr, output logic [31:0] data);
      ocl_arvalid = 1'b1;
      ocl_araddr  = addr;
      do @(negedge clk); while (!ocl_arready);
      step();
      ocl_arvalid = 1'b0;
      ocl_rready  = 1'b1;
      do @(negedge clk); while (!ocl_rvalid);
      data = ocl_rdata;
      step();
      ocl_rready = 1'b0;
   endtask

   task automatic ocl_write(input logic [9:0] addr, input logic [31:0] data);
      ocl_awvalid = 1'b1;
      ocl_wvalid  = 1'b1;
      ocl_awaddr  = addr;
      ocl_wdata   = data;
      ocl_bready  = 1'b1;
      do @(negedge clk); while (!ocl_awready);
      step();
      ocl_awvalid = 1'b0;
      ocl_wvalid  = 1'b0;
      do @(negedge clk); while (!ocl_bvalid);
      step();
      ocl_bready = 1'b0;
   endtask

   // One PCIS burst of len+1 beats
   // Every accepted beat goes to the model
   task automatic pcis_burst(input logic [5:0] id, input int len, input int gap_max,
                             input int bdelay);
      int          gap;
      logic [31:0] word;
      pcis_awvalid = 1'b1;
      pcis_awid    = id;
      pcis_awlen   = 8'(len);
      do @(negedge clk); while (!pcis_awready);
      step();
      pcis_awvalid = 1'b0;
      for (int beat = 0; beat <= len; beat++)
      begin
         gap = (gap_max > 0) ? rand_below(gap_max + 1) : 0;
         repeat (gap) step();
         word = rand_next();
         pcis_wvalid = 1'b1;
         pcis_wdata  = word;
         pcis_wlast  = (beat == len);
         do @(negedge clk); while (!pcis_wready);
         step();
         model_q.push_back(word);
         pcis_wvalid = 1'b0;
         pcis_wlast  = 1'b0;
      end
      do @(negedge clk); while (!pcis_bvalid);
      check_val("pcis_bid", 32'(id), 32'(pcis_bid));
      repeat (bdelay)
      begin
         step();
         @(negedge clk);
         check_val("pcis_bvalid", 32'(1), 32'(pcis_bvalid));
      end
      step();
      pcis_bready = 1'b1;
      step();
      pcis_bready = 1'b0;
   endtask

   task automatic check_count();
      logic [31:0] rd;
      ocl_read(cl_reg_pkg::REG_COUNT, rd);
      check_val("REG_COUNT", 32'(model_q.size()), rd);
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   task automatic check_reset_state();
      int e0;
      e0 = errors;
      @(negedge clk);
      check_val("pcis_awready", 32'(1), 32'(pcis_awready));
      check_val("pcis_wready", 32'(0), 32'(pcis_wready));
      check_val("pcis_bvalid", 32'(0), 32'(pcis_bvalid));
      check_val("ocl_awready", 32'(0), 32'(ocl_awready));
      check_val("ocl_wready", 32'(0), 32'(ocl_wready));
      check_val("ocl_arready", 32'(1), 32'(ocl_arready));
      check_val("ocl_bvalid", 32'(0), 32'(ocl_bvalid));
      check_val("ocl_rvalid", 32'(0), 32'(ocl_rvalid));
      check_val("flr_done", 32'(0), 32'(flr_done));
      check_val("flush", 32'(0), 32'(dut0.flush));
      step();
      check_count();
      finish_test("reset state", e0);
   endtask

   task automatic run_random_bursts();
      int e0;
      e0 = errors;
      for (int i = 0; i < N_BURSTS && model_q.size() + 8 <= DEPTH; i++)
      begin
         pcis_burst(6'(rand_next()), rand_below(8), 2, rand_below(4));
         check_count();
      end
      finish_test("random bursts", e0);
   endtask

   task automatic drain_in_order();
      int          e0;
      logic [31:0] rd;
      e0 = errors;
      while (model_q.size() > 0)
      begin
         ocl_read(cl_reg_pkg::REG_POP, rd);
         check_val("REG_POP", model_q.pop_front(), rd);
      end
      ocl_read(cl_reg_pkg::REG_POP, rd);
      check_val("REG_POP (empty)", 32'(0), rd);
      check_count();
      finish_test("pop order", e0);
   endtask

   task automatic read_id_and_unmapped();
      int          e0;
      logic [31:0] rd;
      e0 = errors;
      ocl_read(cl_reg_pkg::REG_ID, rd);
      check_val("REG_ID", cl_reg_pkg::CL_ID, rd);
      ocl_read(10'h010, rd);
      check_val("ocl_rdata at 0x010", 32'(0), rd);
      ocl_read(10'h3FC, rd);
      check_val("ocl_rdata at 0x3FC", 32'(0), rd);
      finish_test("ID and unmapped reads", e0);
   endtask

   task automatic fill_past_full();
      int          e0;
      int          popped;
      logic [31:0] rd;
      logic [31:0] word;
      e0 = errors;
      popped = 0;
      fork
         begin
            for (int i = 0; i < BP_BURSTS; i++)
               pcis_burst(6'(i + 10), 7, 0, 0);
         end
         begin
            do ocl_read(cl_reg_pkg::REG_COUNT, rd); while (rd != DEPTH);
            // Writer is stalled with a beat pending
            repeat (8)
            begin
               @(negedge clk);
               check_val("pcis_wready", 32'(0), 32'(pcis_wready));
            end
            step();
            while (popped < BP_BEATS)
            begin
               ocl_read(cl_reg_pkg::REG_COUNT, rd);
               repeat (rd)
               begin
                  ocl_read(cl_reg_pkg::REG_POP, word);
                  check_val("REG_POP", model_q.pop_front(), word);
                  popped++;
               end
            end
         end
      join
      check_count();
      assert (popped == BP_BEATS)
      else
      begin
         errors++;
         $display("Drain read back %0d words but %0d were written", popped, BP_BEATS);
      end
      finish_test("back-pressure", e0);
   endtask

   task automatic flush_and_flr();
      int e0;
      e0 = errors;
      pcis_burst(6'h21, 3, 1, 0);
      ocl_write(cl_reg_pkg::REG_CTRL, 32'(1) << cl_reg_pkg::CTRL_FLUSH_BIT);
      model_q.delete();
      check_count();
      pcis_burst(6'h22, 5, 1, 1);
      check_count();
      flr_assert = 1'b1;
      // First sampled at the next edge
      // flr_done pulses on the edge after that
      for (int k = 0; k < 6; k++)
      begin
         @(negedge clk);
         check_val("flr_done", 32'(k == 2), 32'(flr_done));
      end
      step();
      flr_assert = 1'b0;
      model_q.delete();
      check_count();
      finish_test("flush and FLR", e0);
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial
   begin
      lcg_state    = 32'h7c78_06f3;
      pipe_rst_n   = 1'b0;
      pcis_awvalid = 1'b0;
      pcis_awid    = '0;
      pcis_awlen   = '0;
      pcis_wvalid  = 1'b0;
      pcis_wdata   = '0;
      pcis_wlast   = 1'b0;
      pcis_bready  = 1'b0;
      ocl_awvalid  = 1'b0;
      ocl_awaddr   = '0;
      ocl_wvalid   = 1'b0;
      ocl_wdata    = '0;
      ocl_bready   = 1'b0;
      ocl_arvalid  = 1'b0;
      ocl_araddr   = '0;
      ocl_rready   = 1'b0;
      flr_assert   = 1'b0;
      repeat (5) @(posedge clk);
      #0.5;
      pipe_rst_n = 1'b1;

      check_reset_state();
      run_random_bursts();
      drain_in_order();
      read_id_and_unmapped();
      fill_past_full();
      flush_and_flr();

      $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
               tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

/* build.f */
source/cl_bus_pkg.sv
source/cl_reg_pkg.sv
source/pcis_write_capture.sv
source/stream_fifo.sv
source/ocl_slv_regs.sv
source/cl_axis_fifo.sv
bench/cl_axis_fifo_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f \
   --top-module cl_axis_fifo_tb -o cl_axis_fifo_sim
./obj_dir/cl_axis_fifo_sim > sim.log 2>&1
cat sim.log
if grep -q "Simulation finished: PASS" sim.log; then
   exit 0
fi
echo "run.sh: pass message not found in sim.log"
exit 1

/* source/cl_axis_fifo.sv */
`timescale 1ns/1ps

module cl_axis_fifo
#(
   parameter int FIFO_DEPTH = 64
)
(
   input  logic                                clk,
   input  logic                                pipe_rst_n,

   input  logic                                pcis_awvalid,
   output logic                                pcis_awready,
   input  logic [cl_bus_pkg::ID_W-1:0]         pcis_awid,
   input  logic [cl_bus_pkg::LEN_W-1:0]        pcis_awlen,
   input  logic                                pcis_wvalid,
   output logic                                pcis_wready,
   input  logic [cl_bus_pkg::DATA_W-1:0]       pcis_wdata,
   input  logic                                pcis_wlast,
   output logic                                pcis_bvalid,
   output logic [cl_bus_pkg::ID_W-1:0]         pcis_bid,
   input  logic                                pcis_bready,

   input  logic                                ocl_awvalid,
   output logic                                ocl_awready,
   input  logic [cl_reg_pkg::OCL_ADDR_W-1:0]   ocl_awaddr,
   input  logic                                ocl_wvalid,
   output logic                                ocl_wready,
   input  logic [cl_reg_pkg::OCL_DATA_W-1:0]   ocl_wdata,
   output logic                                ocl_bvalid,
   input  logic                                ocl_bready,
   input  logic                                ocl_arvalid,
   output logic                                ocl_arready,
   input  logic [cl_reg_pkg::OCL_ADDR_W-1:0]   ocl_araddr,
   output logic                                ocl_rvalid,
   output logic [cl_reg_pkg::OCL_DATA_W-1:0]   ocl_rdata,
   input  logic                                ocl_rready,

   input  logic                                flr_assert,
   output logic                                flr_done
);

   localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

   // Capture to FIFO
   logic                          push_valid;
   logic                          push_ready;
   logic [cl_bus_pkg::DATA_W-1:0] push_data;

   // FIFO to register block
   logic                          pop_valid;
   logic                          pop_ready;
   logic [cl_bus_pkg::DATA_W-1:0] pop_data;
   logic                          flush;
   logic [CNT_W-1:0]              count;

   //////////////////////////////
   // PCIS write capture
   //////////////////////////////

   pcis_write_capture u_wr_capture (
      .clk        (clk),
      .pipe_rst_n (pipe_rst_n),
      .awvalid    (pcis_awvalid),
      .awready    (pcis_awready),
      .awid       (pcis_awid),
      .awlen      (pcis_awlen),
      .wvalid     (pcis_wvalid),
      .wready     (pcis_wready),
      .wdata      (pcis_wdata),
      .wlast      (pcis_wlast),
      .bvalid     (pcis_bvalid),
      .bid        (pcis_bid),
      .bready     (pcis_bready),
      .push_valid (push_valid),
      .push_data  (push_data),
      .push_ready (push_ready)
   );

   //////////////////////////////
   // Word FIFO
   //////////////////////////////

   stream_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .clk        (clk),
      .pipe_rst_n (pipe_rst_n),
      .push_valid (push_valid),
      .push_ready (push_ready),
      .push_data  (push_data),
      .pop_valid  (pop_valid),
      .pop_ready  (pop_ready),
      .pop_data   (pop_data),
      .flush      (flush),
      .count      (count)
   );

   //////////////////////////////
   // OCL registers and FLR
   //////////////////////////////

   ocl_slv_regs #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_ocl_regs (
      .clk        (clk),
      .pipe_rst_n (pipe_rst_n),
      .awvalid    (ocl_awvalid),
      .awready    (ocl_awready),
      .awaddr     (ocl_awaddr),
      .wvalid     (ocl_wvalid),
      .wready     (ocl_wready),
      .wdata      (ocl_wdata),
      .bvalid     (ocl_bvalid),
      .bready     (ocl_bready),
      .arvalid    (ocl_arvalid),
      .arready    (ocl_arready),
      .araddr     (ocl_araddr),
      .rvalid     (ocl_rvalid),
      .rdata      (ocl_rdata),
      .rready     (ocl_rready),
      .pop_valid  (pop_valid),
      .pop_ready  (pop_ready),
      .pop_data   (pop_data),
      .count      (count),
      .flush      (flush),
      .flr_assert (flr_assert),
      .flr_done   (flr_done)
   );

endmodule

/* source/cl_bus_pkg.sv */
package cl_bus_pkg;

   //////////////////////////////
   // PCIS and FIFO data path
   //////////////////////////////

   // Beat width on the PCIS port, also the FIFO word width
   parameter int DATA_W = 32;

   // Write ID carried from AW to B
   parameter int ID_W = 6;

   // Burst length field, holds beats minus one
   parameter int LEN_W = 8;

   //////////////////////////////
   // Write capture FSM
   //////////////////////////////

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_DATA,
      WR_RESP
   } wr_state_e;

endpackage

/* source/cl_reg_pkg.sv */
package cl_reg_pkg;

   //////////////////////////////
   // OCL bus widths
   //////////////////////////////

   parameter int OCL_ADDR_W = 10;
   parameter int OCL_DATA_W = 32;

   //////////////////////////////
   // Register map
   //////////////////////////////

   typedef enum logic [OCL_ADDR_W-1:0] {
      REG_POP   = 10'h000,
      REG_COUNT = 10'h004,
      REG_ID    = 10'h008,
      REG_CTRL  = 10'h00C
   } ocl_reg_e;

   // Control register bits
   parameter int CTRL_FLUSH_BIT = 0;

   // Design ID returned by REG_ID
   parameter logic [OCL_DATA_W-1:0] CL_ID = 32'hF1F0_0A5C;

endpackage

/* source/ocl_slv_regs.sv */
`timescale 1ns/1ps

module ocl_slv_regs
#(
   parameter int FIFO_DEPTH = 64
)
(
   input  logic                              clk,
   input  logic                              pipe_rst_n,

   input  logic                              awvalid,
   output logic                              awready,
   input  logic [cl_reg_pkg::OCL_ADDR_W-1:0] awaddr,
   input  logic                              wvalid,
   output logic                              wready,
   input  logic [cl_reg_pkg::OCL_DATA_W-1:0] wdata,
   output logic                              bvalid,
   input  logic                              bready,
   input  logic                              arvalid,
   output logic                              arready,
   input  logic [cl_reg_pkg::OCL_ADDR_W-1:0] araddr,
   output logic                              rvalid,
   output logic [cl_reg_pkg::OCL_DATA_W-1:0] rdata,
   input  logic                              rready,

   input  logic                              pop_valid,
   output logic                              pop_ready,
   input  logic [cl_bus_pkg::DATA_W-1:0]     pop_data,
   input  logic [$clog2(FIFO_DEPTH):0]       count,
   output logic                              flush,

   input  logic                              flr_assert,
   output logic                              flr_done
);

   cl_reg_pkg::ocl_reg_e                wr_reg;
   cl_reg_pkg::ocl_reg_e                rd_reg;
   logic                                wr_fire;
   logic                                rd_fire;
   logic                                bvalid_q;
   logic                                rvalid_q;
   logic [cl_reg_pkg::OCL_DATA_W-1:0]   rdata_q;
   logic [cl_reg_pkg::OCL_DATA_W-1:0]   rd_word;
   logic                                ctrl_flush_q;
   logic                                flr_q;
   logic                                flr_seen;
   logic                                flr_rise;

   assign wr_reg = cl_reg_pkg::ocl_reg_e'(awaddr);
   assign rd_reg = cl_reg_pkg::ocl_reg_e'(araddr);

   //////////////////////////////
   // Write channel
   //////////////////////////////

   // Address and data taken together, one response outstanding
   assign wr_fire = awvalid && wvalid && !bvalid_q;
   assign awready = wr_fire;
   assign wready  = wr_fire;
   assign bvalid  = bvalid_q;

   always_ff @(posedge clk)
      if (!pipe_rst_n)
      begin
         bvalid_q     <= 1'b0;
         ctrl_flush_q <= 1'b0;
      end
      else
      begin
         if (wr_fire)
            bvalid_q <= 1'b1;
         else if (bready)
            bvalid_q <= 1'b0;
         ctrl_flush_q <= wr_fire && (wr_reg == cl_reg_pkg::REG_CTRL)
                         && wdata[cl_reg_pkg::CTRL_FLUSH_BIT];
      end

   //////////////////////////////
   // Read channel
   //////////////////////////////

   assign arready = !rvalid_q;
   assign rd_fire = arvalid && arready;
   assign rvalid  = rvalid_q;
   assign rdata   = rdata_q;

   // Pop happens at the address transfer, nothing popped when empty
   assign pop_ready = rd_fire && (rd_reg == cl_reg_pkg::REG_POP);

   always_comb
   begin
      case (rd_reg)
         cl_reg_pkg::REG_POP:
            rd_word = pop_valid ? cl_reg_pkg::OCL_DATA_W'(pop_data) : '0;
         cl_reg_pkg::REG_COUNT:
            rd_word = cl_reg_pkg::OCL_DATA_W'(count);
         cl_reg_pkg::REG_ID:
            rd_word = cl_reg_pkg::CL_ID;
         default:
            rd_word = '0;
      endcase
   end

   always_ff @(posedge clk)
      if (!pipe_rst_n)
         rvalid_q <= 1'b0;
      else if (rd_fire)
         rvalid_q <= 1'b1;
      else if (rready)
         rvalid_q <= 1'b0;

   always_ff @(posedge clk)
      if (rd_fire)
         rdata_q <= rd_word;

   //////////////////////////////
   // FLR response
   //////////////////////////////

   // One pulse per rising edge of the registered request
   assign flr_rise = flr_q && !flr_seen;

   always_ff @(posedge clk)
      if (!pipe_rst_n)
      begin
         flr_q    <= 1'b0;
         flr_seen <= 1'b0;
         flr_done <= 1'b0;
      end
      else
      begin
         flr_q    <= flr_assert;
         flr_seen <= flr_q;
         flr_done <= flr_rise;
      end

   // FLR empties the FIFO on the same edge that raises flr_done
   assign flush = ctrl_flush_q || flr_rise;

   a_rvalid_hold: assert property (@(posedge clk) disable iff (!pipe_rst_n)
      (rvalid && !rready) |=> rvalid);

endmodule

/* source/pcis_write_capture.sv */
`timescale 1ns/1ps

module pcis_write_capture
(
   input  logic                          clk,
   input  logic                          pipe_rst_n,

   input  logic                          awvalid,
   output logic                          awready,
   input  logic [cl_bus_pkg::ID_W-1:0]   awid,
   input  logic [cl_bus_pkg::LEN_W-1:0]  awlen,
   input  logic                          wvalid,
   output logic                          wready,
   input  logic [cl_bus_pkg::DATA_W-1:0] wdata,
   input  logic                          wlast,
   output logic                          bvalid,
   output logic [cl_bus_pkg::ID_W-1:0]   bid,
   input  logic                          bready,

   output logic                          push_valid,
   output logic [cl_bus_pkg::DATA_W-1:0] push_data,
   input  logic                          push_ready
);

   cl_bus_pkg::wr_state_e          state;
   logic [cl_bus_pkg::ID_W-1:0]    id_q;
   logic [cl_bus_pkg::LEN_W-1:0]   len_q;
   logic [cl_bus_pkg::LEN_W-1:0]   beat_cnt;
   logic                           beat_fire;
   logic                           last_beat;

   // One burst in flight, address only taken when idle
   assign awready = (state == cl_bus_pkg::WR_IDLE);

   // Beats go straight through to the FIFO
   assign wready     = (state == cl_bus_pkg::WR_DATA) && push_ready;
   assign push_valid = (state == cl_bus_pkg::WR_DATA) && wvalid;
   assign push_data  = wdata;

   assign bvalid = (state == cl_bus_pkg::WR_RESP);
   assign bid    = id_q;

   assign beat_fire = wvalid && wready;
   assign last_beat = (beat_cnt == len_q);

   //////////////////////////////
   // Burst FSM
   //////////////////////////////

   always_ff @(posedge clk)
      if (!pipe_rst_n)
      begin
         state    <= cl_bus_pkg::WR_IDLE;
         beat_cnt <= '0;
      end
      else
      begin
         case (state)
            cl_bus_pkg::WR_IDLE:
               if (awvalid)
               begin
                  state    <= cl_bus_pkg::WR_DATA;
                  beat_cnt <= '0;
               end
            cl_bus_pkg::WR_DATA:
               if (beat_fire)
               begin
                  beat_cnt <= beat_cnt + 1'b1;
                  // Response only after the final beat is in the FIFO
                  if (last_beat)
                     state <= cl_bus_pkg::WR_RESP;
               end
            cl_bus_pkg::WR_RESP:
               if (bready)
                  state <= cl_bus_pkg::WR_IDLE;
            default:
               state <= cl_bus_pkg::WR_IDLE;
         endcase
      end

   // Burst ID and length, held for the whole burst
   always_ff @(posedge clk)
      if (awvalid && awready)
      begin
         id_q  <= awid;
         len_q <= awlen;
      end

   // Host marks the end exactly where awlen said it would be
   a_wlast_on_count: assert property (@(posedge clk) disable iff (!pipe_rst_n)
      beat_fire |-> (wlast == last_beat));

endmodule

/* source/stream_fifo.sv */
`timescale 1ns/1ps

module stream_fifo
#(
   parameter int FIFO_DEPTH = 64
)
(
   input  logic                          clk,
   input  logic                          pipe_rst_n,

   input  logic                          push_valid,
   output logic                          push_ready,
   input  logic [cl_bus_pkg::DATA_W-1:0] push_data,

   output logic                          pop_valid,
   input  logic                          pop_ready,
   output logic [cl_bus_pkg::DATA_W-1:0] pop_data,

   input  logic                          flush,
   output logic [$clog2(FIFO_DEPTH):0]   count
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   logic [cl_bus_pkg::DATA_W-1:0] mem [FIFO_DEPTH];
   logic [PTR_W-1:0]              wr_ptr;
   logic [PTR_W-1:0]              rd_ptr;
   logic [PTR_W:0]                count_q;
   logic                          do_push;
   logic                          do_pop;

   assign push_ready = (count_q != FIFO_DEPTH);
   assign pop_valid  = (count_q != '0);
   assign pop_data   = mem[rd_ptr];
   assign count      = count_q;

   assign do_push = push_valid && push_ready;
   assign do_pop  = pop_valid && pop_ready;

   // Pointers wrap on their own, depth is a power of two
   always_ff @(posedge clk)
      if (!pipe_rst_n || flush)
      begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count_q <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end

   always_ff @(posedge clk)
      if (do_push)
         mem[wr_ptr] <= push_data;

   // Full and not draining, so the write side must not move
   a_no_push_full: assert property (@(posedge clk) disable iff (!pipe_rst_n)
      (count_q == FIFO_DEPTH && !pop_ready && !flush) |=> $stable(wr_ptr));

   a_count_bound: assert property (@(posedge clk) disable iff (!pipe_rst_n)
      count_q <= FIFO_DEPTH);

endmodule
